// File: lsu_top.f
+incdir+source
source/bus_pkg.sv
source/load_pkg.sv
source/fetch_if.sv
source/shift_if.sv
source/wb_read_master.sv
source/align_shifter.sv
source/load_sequencer.sv
source/lsu_top.sv
tests/lsu_checker.sv
tests/tb_lsu_top.sv

// File: source/align_shifter.sv
// 64-bit rotate register with its rotation counter
// Sign and zero extension of the aligned load result

`timescale 1ns/1ps
`include "lsu_macros.svh"

module align_shifter (
    input  logic                clk,
    input  logic                rst_n,
    shift_if.shifter            shift,
    output bus_pkg::data_word_t load_data
);
    import load_pkg::*;

    // Only the low half is written and read, the high half is reached by rotating
    logic [`LSU_SHIFT_BITS-1:0] shift_reg;

    // Rotations still to do after the current one
    rot_count_t rot_left;
    logic       busy;
    // Current rotation only stages a word into the high half
    logic       staging;

    // A nonzero request rotates on the same edge it is sampled
    logic       rot_active;
    rot_count_t rot_now;

    logic [`LSU_XLEN-1:0] ext_data;

    assign rot_active = busy || (shift.rot_start && shift.rot_amount != '0);
    assign rot_now    = busy ? rot_left : shift.rot_amount;

    // Right rotation by one bit, new word lands in the low half
    always_ff @(posedge clk)
    begin
        if (shift.capture)
            shift_reg[`LSU_XLEN-1:0] <= shift.word;
        else if (rot_active)
            shift_reg <= {shift_reg[0], shift_reg[`LSU_SHIFT_BITS-1:1]};
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            busy           <= 1'b0;
            staging        <= 1'b0;
            rot_left       <= '0;
            shift.rot_done <= 1'b0;
        end
        else
        begin
            shift.rot_done <= 1'b0;
            if (shift.rot_start)
                staging <= (shift.rot_amount == rot_count_t'(`LSU_HALF_ROTATE));
            // Zero amount finishes at once
            if (shift.rot_start && shift.rot_amount == '0)
                shift.rot_done <= 1'b1;
            else if (rot_active)
            begin
                rot_left <= rot_now - 1'b1;
                if (rot_now == rot_count_t'(1))
                begin
                    busy           <= 1'b0;
                    shift.rot_done <= 1'b1;
                end
                else
                    busy <= 1'b1;
            end
        end
    end

    // Extension from the low half, undefined funct gives zero
    always_comb
    begin
        case (shift.funct)
            LB:      ext_data = {{(`LSU_XLEN-8){shift_reg[7]}}, shift_reg[7:0]};
            LH:      ext_data = {{(`LSU_XLEN-16){shift_reg[15]}}, shift_reg[15:0]};
            LW:      ext_data = shift_reg[`LSU_XLEN-1:0];
            LBU:     ext_data = {{(`LSU_XLEN-8){1'b0}}, shift_reg[7:0]};
            LHU:     ext_data = {{(`LSU_XLEN-16){1'b0}}, shift_reg[15:0]};
            default: ext_data = '0;
        endcase
    end

    // Result is taken when the final alignment ends and held until the next one
    always_ff @(posedge clk)
    begin
        if (shift.rot_done && !staging)
            load_data <= ext_data;
    end

    // Sequencer waits for rot_done before any new rotation or capture
    assert property (@(posedge clk) disable iff (!rst_n)
        (shift.rot_start || shift.capture) |-> !busy);

endmodule

// File: source/bus_pkg.sv
// Bus-facing vector types
// Data words, byte addresses and word addresses

`include "lsu_macros.svh"

package bus_pkg;

    // Bus read data and load result
    typedef logic [`LSU_XLEN-1:0] data_word_t;

    // Full byte address as seen by the core
    typedef logic [`LSU_XLEN-1:0] byte_addr_t;

    // Word address, byte offset bits removed
    // Next word is a plain increment that wraps
    typedef logic [`LSU_XLEN-3:0] word_addr_t;

endpackage

// File: source/fetch_if.sv
// Fetch channel between the load sequencer and the bus read master
// One read per req, ended by done or fail

`timescale 1ns/1ps

interface fetch_if;
    import bus_pkg::*;

    // Start pulse, only while no read is pending
    logic req;
    // Held for the whole read including retries
    word_addr_t word_addr;
    // Exactly one of these pulses per req
    logic done;
    logic fail;
    // Valid while done is high
    data_word_t rdata;

    modport seq (
        output req, word_addr,
        input  done, fail, rdata
    );

    modport master (
        input  req, word_addr,
        output done, fail, rdata
    );

endinterface

// File: source/load_pkg.sv
// Load encoding and access size types
// Byte offset, rotation count and sequencer state types

`include "lsu_macros.svh"

package load_pkg;

    // RISC-V load funct3 encodings
    // Values 3, 6 and 7 are undefined and load as words returning zero
    typedef enum logic [2:0] {
        LB  = 3'b000,
        LH  = 3'b001,
        LW  = 3'b010,
        LBU = 3'b100,
        LHU = 3'b101
    } load_funct_t;

    // Access size after decode
    typedef enum logic [1:0] {
        BYTE      = 2'd0,
        HALF_WORD = 2'd1,
        WORD      = 2'd2
    } access_size_t;

    // Byte position within a bus word
    typedef logic [1:0] byte_offset_t;

    // Number of one-bit rotations
    typedef logic [`LSU_COUNT_W-1:0] rot_count_t;

    // Sequencer states
    // High word is only fetched for unaligned requests
    typedef enum logic [2:0] {
        IDLE,
        FETCH_HIGH,
        ROTATE_HIGH,
        FETCH_LOW,
        ALIGN
    } load_state_t;

endpackage

// File: source/load_sequencer.sv
// Load request sequencer
// Decodes size and alignment, orders fetches and rotations

`timescale 1ns/1ps
`include "lsu_macros.svh"

module load_sequencer (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  cyc,
    input  load_pkg::load_funct_t funct3,
    input  bus_pkg::byte_addr_t   address,
    output logic                  ack,
    output logic                  err,
    output logic                  data_valid,
    fetch_if.seq                  fetch,
    shift_if.seq                  shift
);
    import bus_pkg::*;
    import load_pkg::*;

    load_state_t state;

    // Request latched at acceptance
    load_funct_t req_funct;
    byte_addr_t  req_addr;

    access_size_t size;
    byte_offset_t offset;
    logic         unaligned;
    word_addr_t   base_word;
    word_addr_t   next_word;
    rot_count_t   align_amount;

    // Undefined funct3 values decode as word
    always_comb
    begin
        case (req_funct)
            LB, LBU: size = BYTE;
            LH, LHU: size = HALF_WORD;
            default: size = WORD;
        endcase
    end

    assign offset    = req_addr[1:0];
    // Half word crossing at offset 3, word at any nonzero offset
    assign unaligned = (offset == 2'd3 && size != BYTE) || (offset != 2'd0 && size == WORD);
    assign base_word = req_addr[`LSU_XLEN-1:2];
    // Wraps at the top of the address space
    assign next_word = base_word + 1'b1;
    // 8 bits per byte of offset
    assign align_amount = rot_count_t'({offset, 3'b000});

    // Fetched data goes straight into the low half
    assign shift.capture = fetch.done && (state == FETCH_HIGH || state == FETCH_LOW);
    assign shift.word    = fetch.rdata;
    assign shift.funct   = req_funct;

    // Funct3 and address captured in the cycle cyc is accepted
    always_ff @(posedge clk)
    begin
        if (state == IDLE && !ack && cyc)
        begin
            req_funct <= funct3;
            req_addr  <= address;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state           <= IDLE;
            ack             <= 1'b0;
            err             <= 1'b0;
            data_valid      <= 1'b0;
            fetch.req       <= 1'b0;
            shift.rot_start <= 1'b0;
        end
        else
        begin
            ack             <= 1'b0;
            err             <= 1'b0;
            data_valid      <= 1'b0;
            fetch.req       <= 1'b0;
            shift.rot_start <= 1'b0;
            case (state)
                IDLE:
                begin
                    // Ack cycle launches the first read from the latched request
                    if (ack)
                    begin
                        fetch.req       <= 1'b1;
                        fetch.word_addr <= unaligned ? next_word : base_word;
                        state           <= unaligned ? FETCH_HIGH : FETCH_LOW;
                    end
                    else if (cyc)
                        ack <= 1'b1;
                end
                FETCH_HIGH:
                begin
                    // Move the high word into the upper half
                    if (fetch.done)
                    begin
                        shift.rot_start  <= 1'b1;
                        shift.rot_amount <= rot_count_t'(`LSU_HALF_ROTATE);
                        state            <= ROTATE_HIGH;
                    end
                    else if (fetch.fail)
                    begin
                        err   <= 1'b1;
                        state <= IDLE;
                    end
                end
                ROTATE_HIGH:
                begin
                    if (shift.rot_done)
                    begin
                        fetch.req       <= 1'b1;
                        fetch.word_addr <= base_word;
                        state           <= FETCH_LOW;
                    end
                end
                FETCH_LOW:
                begin
                    if (fetch.done)
                    begin
                        shift.rot_start  <= 1'b1;
                        shift.rot_amount <= align_amount;
                        state            <= ALIGN;
                    end
                    else if (fetch.fail)
                    begin
                        err   <= 1'b1;
                        state <= IDLE;
                    end
                end
                ALIGN:
                begin
                    if (shift.rot_done)
                    begin
                        data_valid <= 1'b1;
                        state      <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // A request ends in exactly one way
    assert property (@(posedge clk) disable iff (!rst_n) !(data_valid && err));

endmodule

// File: source/lsu_macros.svh
// Width and count macros shared by the load unit
// Data path, rotate register and rotation counter sizes

`ifndef LSU_MACROS_SVH
`define LSU_MACROS_SVH

// Bus and load data width
`define LSU_XLEN 32

// Rotate register holds two bus words
`define LSU_SHIFT_BITS 64

// Rotations that move the low half into the high half
`define LSU_HALF_ROTATE 32

// Rotation counter width, enough for a half rotate
`define LSU_COUNT_W 6

`endif

// File: source/lsu_top.sv
// Load unit top level
// Sequencer, Wishbone read master and alignment shifter

`timescale 1ns/1ps

module lsu_top (
    input  logic                  clk,
    input  logic                  rst_n,
    // Core request side
    input  logic                  cyc,
    input  load_pkg::load_funct_t funct3,
    input  bus_pkg::byte_addr_t   address,
    output logic                  ack,
    output logic                  err,
    output logic                  data_valid,
    output bus_pkg::data_word_t   load_data,
    // Wishbone read master side
    input  logic                  wb_ack,
    input  logic                  wb_err,
    input  logic                  wb_rty,
    input  bus_pkg::data_word_t   wb_rdata,
    output logic                  wb_cyc,
    output logic                  wb_stb,
    output bus_pkg::byte_addr_t   wb_adr
);

    fetch_if fetch_bus ();
    shift_if shift_bus ();

    // Request decode and ordering
    load_sequencer u_seq (
        .clk        (clk),
        .rst_n      (rst_n),
        .cyc        (cyc),
        .funct3     (funct3),
        .address    (address),
        .ack        (ack),
        .err        (err),
        .data_valid (data_valid),
        .fetch      (fetch_bus),
        .shift      (shift_bus)
    );

    // Single word reads with retry
    wb_read_master u_master (
        .clk      (clk),
        .rst_n    (rst_n),
        .fetch    (fetch_bus),
        .wb_ack   (wb_ack),
        .wb_err   (wb_err),
        .wb_rty   (wb_rty),
        .wb_rdata (wb_rdata),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_adr   (wb_adr)
    );

    // Rotate register and extension
    align_shifter u_shifter (
        .clk       (clk),
        .rst_n     (rst_n),
        .shift     (shift_bus),
        .load_data (load_data)
    );

endmodule

// File: source/shift_if.sv
// Control channel between the load sequencer and the alignment shifter
// Capture, rotate requests and extension select

`timescale 1ns/1ps

interface shift_if;
    import bus_pkg::*;
    import load_pkg::*;

    // Writes word into the low half of the rotate register
    logic capture;
    data_word_t word;
    // Rotation request, amount held with the pulse
    logic rot_start;
    rot_count_t rot_amount;
    // Cycle after the last one-bit rotation
    logic rot_done;
    // Picks sign or zero extension of the result
    load_funct_t funct;

    modport seq (
        output capture, word, rot_start, rot_amount, funct,
        input  rot_done
    );

    modport shifter (
        input  capture, word, rot_start, rot_amount, funct,
        output rot_done
    );

endinterface

// File: source/wb_read_master.sv
// Wishbone read master for single word reads
// Reissues on retry, reports ack as done and err as fail

`timescale 1ns/1ps

module wb_read_master (
    input  logic                clk,
    input  logic                rst_n,
    fetch_if.master             fetch,
    input  logic                wb_ack,
    input  logic                wb_err,
    input  logic                wb_rty,
    input  bus_pkg::data_word_t wb_rdata,
    output logic                wb_cyc,
    output logic                wb_stb,
    output bus_pkg::byte_addr_t wb_adr
);

    // Set for the idle cycle between a retry and the reissued read
    logic retry_gap;

    // Termination decode, ack wins over err, err over rty
    logic term_ack;
    logic term_err;
    logic term_rty;

    assign term_ack = wb_cyc && wb_ack;
    assign term_err = wb_cyc && !wb_ack && wb_err;
    assign term_rty = wb_cyc && !wb_ack && !wb_err && wb_rty;

    // Address is held by the sequencer until done or fail
    assign wb_adr = {fetch.word_addr, 2'b00};

    // Results go straight back to the sequencer
    assign fetch.done  = term_ack;
    assign fetch.fail  = term_err;
    assign fetch.rdata = wb_rdata;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            wb_cyc    <= 1'b0;
            wb_stb    <= 1'b0;
            retry_gap <= 1'b0;
        end
        else if (fetch.req || retry_gap)
        begin
            // New read, or the same read again after the gap
            wb_cyc    <= 1'b1;
            wb_stb    <= 1'b1;
            retry_gap <= 1'b0;
        end
        else if (term_ack || term_err || term_rty)
        begin
            // Any termination drops the cycle
            wb_cyc    <= 1'b0;
            wb_stb    <= 1'b0;
            retry_gap <= term_rty;
        end
    end

    // Strobe only inside a bus cycle
    assert property (@(posedge clk) disable iff (!rst_n) wb_stb |-> wb_cyc);

    // Sequencer never starts a read while one is pending or being retried
    assert property (@(posedge clk) disable iff (!rst_n)
        fetch.req |-> !wb_cyc && !retry_gap);

endmodule

// File: tests/lsu_checker.sv
// Monitor for the load unit
// Tracks bus reads per request and models the expected load value

`timescale 1ns/1ps

module lsu_checker (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  cyc,
    input  load_pkg::load_funct_t funct3,
    input  bus_pkg::byte_addr_t   address,
    input  logic                  ack,
    input  logic                  err,
    input  logic                  data_valid,
    input  bus_pkg::data_word_t   load_data,
    input  logic                  wb_cyc,
    input  logic                  wb_stb,
    input  bus_pkg::byte_addr_t   wb_adr,
    input  logic                  wb_ack,
    input  logic                  wb_err,
    input  logic                  wb_rty,
    input  bus_pkg::data_word_t   wb_rdata,
    output int                    error_count,
    output int                    load_count,
    output int                    fail_count,
    output int                    retry_count
);
    import bus_pkg::*;

    // Request in flight as seen on the ports
    logic       busy;
    logic       ack_due;
    logic       bus_failed;
    logic       reset_seen;
    logic       prev_cyc;
    logic       have_data;
    logic [2:0] req_funct;
    byte_addr_t req_addr;
    int         n_reads;
    int         read_idx;
    // Expected word addresses in bus order and the data each one returned
    word_addr_t read_word [2];
    data_word_t read_data [2];
    data_word_t held_data;
    data_word_t expect_word;

    // Half word at offset 3 or word at a nonzero offset spans two words
    function automatic logic crosses_word(logic [2:0] f, logic [1:0] off);
        case (f)
            3'd0, 3'd4: return 1'b0;
            3'd1, 3'd5: return off == 2'd3;
            default:    return off != 2'd0;
        endcase
    endfunction

    // Bytes from the offset onward
    // First read is the upper word when two are made
    function automatic data_word_t expected_load(logic [2:0] f, logic [1:0] off,
                                                 data_word_t first, data_word_t second,
                                                 logic two_reads);
        logic [63:0] pair;
        logic [31:0] win;
        pair = two_reads ? {first, second} : {32'h0, first};
        pair = pair >> (8 * off);
        win  = pair[31:0];
        case (f)
            3'd0:    return {{24{win[7]}}, win[7:0]};
            3'd1:    return {{16{win[15]}}, win[15:0]};
            3'd2:    return win;
            3'd4:    return {24'h0, win[7:0]};
            3'd5:    return {16'h0, win[15:0]};
            // Undefined encodings
            default: return '0;
        endcase
    endfunction

    always @(posedge clk)
    begin
        if (!rst_n)
        begin
            busy       = 1'b0;
            ack_due    = 1'b0;
            bus_failed = 1'b0;
            reset_seen = 1'b0;
            prev_cyc   = 1'b0;
            have_data  = 1'b0;
        end
        else
        begin
            // First cycle out of reset shows the reset values
            if (!reset_seen && (ack || err || data_valid || wb_cyc || wb_stb) !== 1'b0)
            begin
                $display("control outputs not low after reset at %0t", $time);
                error_count++;
            end
            reset_seen = 1'b1;
            if (ack !== ack_due)
            begin
                $display("ack pulse out of place at %0t (ack %b)", $time, ack);
                error_count++;
            end
            ack_due = 1'b0;

            // Single reads raise and drop strobe together with the cycle
            if (wb_stb !== wb_cyc)
            begin
                $display("mismatch at %0t: wb_stb %b, expected %b", $time, wb_stb, wb_cyc);
                error_count++;
            end

            // Each bus cycle start including retries must hit the pending word
            if (wb_cyc && !prev_cyc)
            begin
                if (!busy || bus_failed || read_idx >= n_reads)
                begin
                    $display("bus read started with no read pending at %0t", $time);
                    error_count++;
                end
                else if (wb_adr !== {read_word[read_idx], 2'b00})
                begin
                    $display("mismatch at %0t: wb_adr %h, expected %h", $time, wb_adr,
                             {read_word[read_idx], 2'b00});
                    error_count++;
                end
            end
            if (wb_cyc && wb_ack)
            begin
                if (busy && read_idx < n_reads)
                begin
                    read_data[read_idx] = wb_rdata;
                    read_idx++;
                end
            end
            else if (wb_cyc && wb_err)
                bus_failed = 1'b1;
            else if (wb_cyc && wb_rty)
                retry_count++;
            prev_cyc = wb_cyc;

            if (data_valid && err)
            begin
                $display("data_valid and err high together at %0t", $time);
                error_count++;
            end
            if (data_valid)
            begin
                if (!busy || bus_failed || read_idx != n_reads)
                begin
                    $display("data_valid without a completed load at %0t", $time);
                    error_count++;
                end
                else
                begin
                    expect_word = expected_load(req_funct, req_addr[1:0], read_data[0],
                                                read_data[1], n_reads == 2);
                    if (load_data !== expect_word)
                    begin
                        $display("mismatch at %0t: load_data %h, expected %h %s %0d addr %h)",
                                 $time, load_data, expect_word, "(funct3", req_funct,
                                 req_addr);
                        error_count++;
                    end
                    load_count++;
                end
                held_data = load_data;
                have_data = 1'b1;
                busy      = 1'b0;
            end
            else if (have_data && load_data !== held_data)
            begin
                $display("mismatch at %0t: load_data changed to %h without data_valid",
                         $time, load_data);
                error_count++;
                held_data = load_data;
            end
            if (err)
            begin
                if (!busy || !bus_failed)
                begin
                    $display("err pulse without a bus error at %0t", $time);
                    error_count++;
                end
                fail_count++;
                busy = 1'b0;
            end

            // Request latched as cyc is accepted
            if (!busy && cyc)
            begin
                busy       = 1'b1;
                ack_due    = 1'b1;
                bus_failed = 1'b0;
                read_idx   = 0;
                req_funct  = funct3;
                req_addr   = address;
                if (crosses_word(req_funct, req_addr[1:0]))
                begin
                    n_reads      = 2;
                    // Next word wraps at the top of the address space
                    read_word[0] = req_addr[31:2] + 30'd1;
                    read_word[1] = req_addr[31:2];
                end
                else
                begin
                    n_reads      = 1;
                    read_word[0] = req_addr[31:2];
                end
            end
        end
    end

endmodule

// File: tests/tb_lsu_top.sv
// Testbench for the load unit
// Clock, reset, random load requests, Wishbone slave model and watchdog

`timescale 1ns/1ps

module tb_lsu_top;
    import bus_pkg::*;
    import load_pkg::*;

    localparam int CLK_PERIOD = 20;
    localparam int NUM_REQ    = 400;
    // Generous average budget per request for the watchdog
    localparam int REQ_CYCLES = 150;

    logic        clk;
    logic        rst_n;
    logic        cyc;
    load_funct_t funct3;
    byte_addr_t  address;
    logic        ack;
    logic        err;
    logic        data_valid;
    data_word_t  load_data;
    logic        wb_ack;
    logic        wb_err;
    logic        wb_rty;
    data_word_t  wb_rdata;
    logic        wb_cyc;
    logic        wb_stb;
    byte_addr_t  wb_adr;
    int          error_count;
    int          load_count;
    int          fail_count;
    int          retry_count;
    // Separate generator streams for requests and slave responses
    logic [31:0] stim_state;
    logic [31:0] slave_state;

    function automatic logic [31:0] lcg_step(logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Scrambled memory contents, every address bit matters
    function automatic data_word_t mem_word(byte_addr_t a);
        return (a * 32'h9e3779b1) ^ {a[15:0], a[31:16]} ^ 32'h5bd1e995;
    endfunction

    lsu_top uut (
        .clk        (clk),
        .rst_n      (rst_n),
        .cyc        (cyc),
        .funct3     (funct3),
        .address    (address),
        .ack        (ack),
        .err        (err),
        .data_valid (data_valid),
        .load_data  (load_data),
        .wb_ack     (wb_ack),
        .wb_err     (wb_err),
        .wb_rty     (wb_rty),
        .wb_rdata   (wb_rdata),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_adr     (wb_adr)
    );

    lsu_checker u_check (
        .clk (clk), .rst_n (rst_n), .cyc (cyc), .funct3 (funct3), .address (address),
        .ack (ack), .err (err), .data_valid (data_valid), .load_data (load_data),
        .wb_cyc (wb_cyc), .wb_stb (wb_stb), .wb_adr (wb_adr), .wb_ack (wb_ack),
        .wb_err (wb_err), .wb_rty (wb_rty), .wb_rdata (wb_rdata),
        .error_count (error_count), .load_count (load_count),
        .fail_count (fail_count), .retry_count (retry_count)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // One random load, with an optional stray cyc while it is in flight
    task automatic send_request();
        logic [31:0] hi;
        logic        stray;
        int          gap;
        stim_state = lcg_step(stim_state);
        hi         = stim_state;
        stim_state = lcg_step(stim_state);
        address    = {hi[31:16], stim_state[31:16]};
        stim_state = lcg_step(stim_state);
        funct3     = load_funct_t'(stim_state[31:29]);
        // Last word of memory so the next word wraps
        if (stim_state[28:25] == 4'd0)
            address[31:2] = '1;
        stray = (stim_state[24:23] == 2'd0);
        gap   = stim_state[22:21];
        repeat (gap) @(negedge clk);
        cyc = 1'b1;
        @(negedge clk);
        cyc = 1'b0;
        // Ack cycle, sequencer is busy from here
        @(negedge clk);
        if (stray)
        begin
            cyc     = 1'b1;
            address = ~address;
            @(negedge clk);
            cyc = 1'b0;
        end
        while (!(data_valid || err))
            @(negedge clk);
    endtask

    initial
    begin
        rst_n      = 1'b0;
        cyc        = 1'b0;
        funct3     = LB;
        address    = '0;
        wb_ack     = 1'b0;
        wb_err     = 1'b0;
        wb_rty     = 1'b0;
        wb_rdata   = '0;
        stim_state = 32'hceabaeb3;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        for (int n = 0; n < NUM_REQ; n++)
            send_request();
        repeat (4) @(negedge clk);
        if (load_count + fail_count != NUM_REQ)
            $display("completed %0d requests out of %0d sent", load_count + fail_count, NUM_REQ);
        $display("errors %0d, loads %0d, failed loads %0d, retries %0d",
                 error_count, load_count, fail_count, retry_count);
        if (error_count == 0 && load_count + fail_count == NUM_REQ)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

    // Wishbone slave, answers after 0 to 4 cycles
    initial
    begin : slave_model
        int delay;
        int pick;
        slave_state = 32'hceabaeb3 ^ 32'h2545f491;
        forever
        begin
            @(negedge clk);
            wb_ack = 1'b0;
            wb_err = 1'b0;
            wb_rty = 1'b0;
            if (wb_cyc && wb_stb)
            begin
                slave_state = lcg_step(slave_state);
                delay       = (slave_state >> 16) % 5;
                slave_state = lcg_step(slave_state);
                pick        = (slave_state >> 16) % 40;
                repeat (delay) @(negedge clk);
                // About 1 in 40 errors and 1 in 8 retries
                if (pick == 0)
                    wb_err = 1'b1;
                else if (pick < 6)
                    wb_rty = 1'b1;
                else
                begin
                    wb_ack   = 1'b1;
                    wb_rdata = mem_word(wb_adr);
                end
            end
        end
    end

    // Watchdog over the whole run
    initial
    begin
        #(NUM_REQ * REQ_CYCLES * CLK_PERIOD);
        $display("timeout: requests still outstanding after %0d cycles", NUM_REQ * REQ_CYCLES);
        $display("Simulation FAILED");
        $finish;
    end

endmodule
